// File: build.f
+incdir+hdl
hdl/sram_pkg.sv
hdl/sync_fifo.sv
hdl/spi_byte_shifter.sv
hdl/spi_sram_ctrl.sv
hdl/sram_self_test.sv
hdl/sram_test_top.sv
sim/spi_sram_model.sv
sim/tb_sram_asserts.sv
sim/tb_sram_test.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sram_test \
    -f build.f -o tb_sram_test || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_sram_test)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim/tb_sram_test.sv
`timescale 1ns/1ps
`include "sram_defines.svh"

module tb_sram_test import sram_pkg::*; ();

    localparam int     RUN_LIMIT   = (8 + 8 * `SRAM_FIFO_DEPTH) * 40 + 100;   // Cycles per run
    localparam longint WATCHDOG_NS = 40 * (8 + 8 * `SRAM_FIFO_DEPTH) * 32 * 20 + 200000;

    logic         pll_clk = 1'b0;
    logic         rst_n;
    logic         start;
    sram_addr_t   base_addr;
    logic [5:0]   len;
    logic         busy;
    logic         done;
    test_result_t result;
    logic         cs_n;
    logic         sck;
    logic         mosi;
    logic         miso;
    logic         flip_en;
    logic [15:0]  flip_addr;
    logic [7:0]   flip_mask;
    logic [15:0]  lfsr = 16'd50;
    logic [7:0]   shadow [65536];   // Expected SRAM bytes
    int           errors = 0;
    int           checks = 0;
    int           done_count = 0;

    sram_test_top UUT (
        .pll_clk, .rst_n, .start, .base_addr, .len, .busy, .done, .result,
        .cs_n, .sck, .mosi, .miso
    );

    spi_sram_model u_sram_model (.cs_n, .sck, .mosi, .miso, .flip_en, .flip_addr, .flip_mask);

    bind spi_byte_shifter tb_sram_asserts u_asserts (
        .pll_clk, .rst_n, .byte_go, .byte_done, .cs_n, .sck, .mosi
    );

    always #10 pll_clk = ~pll_clk;

    always @(negedge pll_clk) begin
        if (done) begin
            done_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Word i of a run is A5A5 over the low base bits plus i
    function automatic sram_word_t expected_word(input sram_addr_t base, input int i);
        return {16'hA5A5, 16'(base[15:0] + i)};
    endfunction

    task automatic check_range(input sram_addr_t base, input int nbytes);
        logic [15:0] a;
        for (int i = 0; i < nbytes; i++) begin
            a = 16'(base + i);
            checks++;
            if (u_sram_model.mem[a] !== shadow[a]) begin
                errors++;
                $display("MISMATCH at %0t: SRAM byte %h is %h, expected %h",
                         $time, a, u_sram_model.mem[a], shadow[a]);
            end
        end
    endtask

    // Flip one bit in k consecutive words once the write burst has ended
    task automatic inject_faults(input sram_addr_t base, input logic [5:0] n, input int k);
        int          cycles;
        int          first;
        int          bitn;
        logic [31:0] r;
        logic [15:0] a;
        cycles = 0;
        while (cs_n === 1'b1 && cycles < RUN_LIMIT) begin
            @(negedge pll_clk);
            cycles++;
        end
        while (cs_n === 1'b0 && cycles < RUN_LIMIT) begin
            @(negedge pll_clk);
            cycles++;
        end
        rand_bits(5, r);
        first = int'(r % n);
        for (int j = 0; j < k; j++) begin
            rand_bits(5, r);
            bitn      = int'(r);
            a         = 16'(base + 4 * ((first + j) % n) + bitn / 8);
            flip_addr = a;
            flip_mask = 8'h01 << (bitn % 8);
            shadow[a] = shadow[a] ^ flip_mask;
            flip_en   = 1'b1;
            #1;
            flip_en   = 1'b0;
            #1;
        end
    endtask

    task automatic run_test(input sram_addr_t base, input logic [5:0] n, input int k,
                            input bit poke);
        int         cnt_before;
        int         cycles;
        sram_word_t wd;
        cnt_before = done_count;
        for (int i = 0; i < n; i++) begin
            wd = expected_word(base, i);
            for (int j = 0; j < 4; j++) begin
                shadow[16'(base + 4 * i + j)] = wd[8 * j +: 8];   // LSB at the lowest address
            end
        end
        @(posedge pll_clk);
        #1;
        base_addr = base;
        len       = n;
        start     = 1'b1;
        @(posedge pll_clk);
        #1;
        start = 1'b0;
        checks++;
        if (busy !== 1'b1) begin
            errors++;
            $display("MISMATCH at %0t: busy=%b after start, expected 1", $time, busy);
        end
        if (poke) begin
            repeat (5) @(posedge pll_clk);
            #1;
            base_addr = base ^ 24'h000100;
            len       = 6'd1;
            start     = 1'b1;
            @(posedge pll_clk);
            #1;
            start = 1'b0;
        end
        if (k > 0) begin
            inject_faults(base, n, k);
        end
        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge pll_clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("ERROR at %0t: no done within %0d cycles of start", $time, RUN_LIMIT);
        end else begin
            checks++;
            if (result.pass !== (k == 0) || result.err_count !== 6'(k)) begin
                errors++;
                $display("MISMATCH at %0t: pass=%b err_count=%0d, expected pass=%b count=%0d",
                         $time, result.pass, result.err_count, k == 0, k);
            end
            repeat (8) @(negedge pll_clk);
            checks++;
            if (done_count != cnt_before + 1 || busy) begin
                errors++;
                $display("MISMATCH at %0t: %0d done strobes for one start, busy=%b",
                         $time, done_count - cnt_before, busy);
            end
            check_range(base, 4 * n);
        end
    endtask

    initial begin
        logic [31:0] r;
        sram_addr_t  b;
        int          k;
        rst_n     = 1'b0;
        start     = 1'b0;
        base_addr = '0;
        len       = 6'd1;
        flip_en   = 1'b0;
        flip_addr = '0;
        flip_mask = '0;
        repeat (3) @(posedge pll_clk);
        #1;
        rst_n = 1'b1;
        @(negedge pll_clk);
        checks++;
        if (cs_n !== 1'b1 || busy !== 1'b0 || done !== 1'b0) begin
            errors++;
            $display("MISMATCH at %0t: after reset cs_n=%b busy=%b done=%b",
                     $time, cs_n, busy, done);
        end
        for (int i = 0; i < 5; i++) begin
            rand_bits(24, r);
            b = 24'(r);
            rand_bits(5, r);
            run_test(b, 6'(r) + 6'd1, 0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            rand_bits(24, r);
            b = 24'(r);
            rand_bits(2, r);
            k = int'(r % 3) + 1;
            rand_bits(4, r);
            run_test(b, 6'(r) + 6'd4, k, 1'b0);
        end
        rand_bits(24, r);
        run_test(24'(r), 6'(`SRAM_FIFO_DEPTH), 0, 1'b0);     // Write FIFO fills up
        rand_bits(24, r);
        b = 24'(r);
        run_test(b, 6'd16, 0, 1'b0);
        run_test(b + 24'd24, 6'd20, 0, 1'b0);   // Overlaps the last 40 bytes of the run before
        check_range(b, 64);
        rand_bits(24, r);
        run_test(24'(r), 6'd8, 0, 1'b1);
        $display("Checks %0d, errors %0d, done strobes %0d", checks, errors, done_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_sram_asserts.sv
`timescale 1ns/1ps

module tb_sram_asserts (
    input logic pll_clk,
    input logic rst_n,
    input logic byte_go,
    input logic byte_done,
    input logic cs_n,
    input logic sck,
    input logic mosi
);

    logic pending;  // A byte was started and has not completed yet

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (byte_go) begin
            pending <= 1'b1;
        end else if (byte_done) begin
            pending <= 1'b0;
        end
    end

    cs_fall_needs_go: assert property (@(posedge pll_clk) disable iff (!rst_n)
        $fell(cs_n) |-> $past(byte_go)) else $error("cs_n fell without a byte start");

    sck_low_when_idle: assert property (@(posedge pll_clk) disable iff (!rst_n)
        cs_n |-> !sck) else $error("sck toggled while cs_n high");

    done_after_go: assert property (@(posedge pll_clk) disable iff (!rst_n)
        byte_done |-> pending) else $error("byte_done without a started byte");

    mosi_stable_sck_high: assert property (@(posedge pll_clk) disable iff (!rst_n)
        sck |-> $stable(mosi)) else $error("mosi changed while sck high");

endmodule

// File: sim/spi_sram_model.sv
`timescale 1ns/1ps
`include "sram_defines.svh"

// Serial SRAM in SPI mode 0, 64 KB array addressed by the low 16 address bits
module spi_sram_model (
    input  logic        cs_n,
    input  logic        sck,
    input  logic        mosi,
    output logic        miso,
    input  logic        flip_en,    // Rising edge flips bits while deselected
    input  logic [15:0] flip_addr,
    input  logic [7:0]  flip_mask
);

    logic [7:0]  mem [65536];
    logic [7:0]  sr;
    logic [7:0]  cmd;
    logic [7:0]  out_byte;
    logic [23:0] addr;
    logic [2:0]  bit_cnt;
    logic        rd_mode;   // Data phase of a read
    int          byte_idx;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
    end

    always @(posedge sck or posedge cs_n or posedge flip_en) begin
        if (cs_n) begin
            bit_cnt  = '0;
            byte_idx = 0;
            rd_mode  = 1'b0;
            if (flip_en) begin
                mem[flip_addr] = mem[flip_addr] ^ flip_mask;
            end
        end else begin
            sr = {sr[6:0], mosi};
            if (bit_cnt == 3'd7) begin
                case (byte_idx)
                    0: cmd = sr;
                    1: addr[23:16] = sr;
                    2: addr[15:8] = sr;
                    3: addr[7:0] = sr;
                    default: begin
                        if (cmd == `SRAM_CMD_WRITE) begin
                            mem[addr[15:0]] = sr;
                            addr = addr + 24'd1;
                        end
                    end
                endcase
                // Next read byte is fetched as soon as the previous one is out
                if (cmd == `SRAM_CMD_READ && byte_idx >= 3) begin
                    rd_mode  = 1'b1;
                    out_byte = mem[addr[15:0]];
                    addr     = addr + 24'd1;
                end
                byte_idx++;
            end
            bit_cnt = bit_cnt + 3'd1;
        end
    end

    always @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            miso <= 1'b0;
        end else begin
            miso <= rd_mode ? out_byte[3'd7 - bit_cnt] : 1'b0;   // MSB first
        end
    end

endmodule

// File: hdl/sram_test_top.sv
`timescale 1ns/1ps

module sram_test_top import sram_pkg::*; (
    input  logic         pll_clk,
    input  logic         rst_n,
    input  logic         start,
    input  sram_addr_t   base_addr,
    input  logic [5:0]   len,
    output logic         busy,
    output logic         done,
    output test_result_t result,
    output logic         cs_n,
    output logic         sck,
    output logic         mosi,
    input  logic         miso
);

    logic       req_valid;
    sram_req_t  req;
    logic       ctrl_done;
    logic       wr_push;
    sram_word_t wr_word;
    logic       rd_pop;
    sram_word_t rd_word;
    logic       rd_empty;
    logic       byte_go;
    logic [7:0] tx_byte;
    logic       last;
    logic       byte_done;
    logic [7:0] rx_byte;

    sram_self_test u_self_test (
        .pll_clk, .rst_n, .start, .base_addr, .len, .busy, .done, .result,
        .req_valid, .req, .ctrl_done, .wr_push, .wr_word, .rd_pop, .rd_word, .rd_empty
    );

    spi_sram_ctrl u_ctrl (
        .pll_clk, .rst_n, .req_valid, .req, .ctrl_done, .wr_push, .wr_word,
        .rd_pop, .rd_word, .rd_empty, .byte_go, .tx_byte, .last, .byte_done, .rx_byte
    );

    spi_byte_shifter u_shifter (
        .pll_clk, .rst_n, .byte_go, .tx_byte, .last, .byte_done, .rx_byte,
        .cs_n, .sck, .mosi, .miso
    );

endmodule

// File: hdl/sram_self_test.sv
`timescale 1ns/1ps

module sram_self_test import sram_pkg::*; (
    input  logic         pll_clk,
    input  logic         rst_n,
    input  logic         start,
    input  sram_addr_t   base_addr,
    input  logic [5:0]   len,
    output logic         busy,
    output logic         done,
    output test_result_t result,
    output logic         req_valid,
    output sram_req_t    req,
    input  logic         ctrl_done,
    output logic         wr_push,
    output sram_word_t   wr_word,
    output logic         rd_pop,
    input  sram_word_t   rd_word,
    input  logic         rd_empty
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE,
        ST_WAIT_WR,
        ST_READ,
        ST_CHECK    // Read burst running, words compared as they arrive
    } state_t;

    state_t     state;
    sram_addr_t base_q;
    logic [5:0] len_q;
    logic [5:0] idx;        // Fill index, then compare index
    logic [5:0] err_cnt;

    function automatic sram_word_t pattern(input sram_addr_t base, input logic [5:0] i);
        pattern = {16'hA5A5, base[15:0] + {10'd0, i}};
    endfunction

    assign busy      = (state != ST_IDLE);
    assign wr_push   = (state == ST_FILL);
    assign wr_word   = pattern(base_q, idx);
    assign req_valid = (state == ST_WRITE) || (state == ST_READ);
    assign req.op    = (state == ST_READ) ? SRAM_OP_READ : SRAM_OP_WRITE;
    assign req.addr  = base_q;
    assign req.len   = len_q;
    assign rd_pop    = (state == ST_CHECK) && !rd_empty;

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            idx     <= '0;
            err_cnt <= '0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        idx     <= '0;
                        err_cnt <= '0;
                        result  <= '0;
                        state   <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    idx <= idx + 6'd1;
                    if (idx == len_q - 6'd1) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: state <= ST_WAIT_WR;
                ST_WAIT_WR: begin
                    if (ctrl_done) begin
                        idx   <= '0;
                        state <= ST_READ;
                    end
                end
                ST_READ: state <= ST_CHECK;
                ST_CHECK: begin
                    if (rd_pop) begin
                        idx <= idx + 6'd1;
                        if (rd_word != pattern(base_q, idx)) begin
                            err_cnt <= err_cnt + 6'd1;
                        end
                    end
                    // Last word lands after the final byte, so the count covers ctrl_done
                    if (idx == len_q) begin
                        done             <= 1'b1;
                        result.pass      <= (err_cnt == 6'd0);
                        result.err_count <= err_cnt;
                        state            <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (state == ST_IDLE && start) begin
            base_q <= base_addr;
            len_q  <= len;
        end
    end

endmodule

// File: hdl/spi_sram_ctrl.sv
`timescale 1ns/1ps
`include "sram_defines.svh"

module spi_sram_ctrl import sram_pkg::*; (
    input  logic       pll_clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  sram_req_t  req,
    output logic       ctrl_done,
    input  logic       wr_push,
    input  sram_word_t wr_word,
    input  logic       rd_pop,
    output sram_word_t rd_word,
    output logic       rd_empty,
    output logic       byte_go,
    output logic [7:0] tx_byte,
    output logic       last,
    input  logic       byte_done,
    input  logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        CT_IDLE,
        CT_GO,
        CT_WAIT
    } ctrl_state_t;

    ctrl_state_t state;
    sram_req_t   req_q;
    logic [7:0]  byte_cnt;  // 0 is the command, 1..3 the address, then data
    logic [7:0]  last_idx;
    logic        is_data;
    logic        is_read;
    sram_word_t  wr_head;
    logic        wr_pop;
    logic        rd_push;
    logic [23:0] rd_asm;    // First three bytes of the word being read

    assign last_idx = {req_q.len, 2'b00} + 8'd3;
    assign is_data  = (byte_cnt[7:2] != 6'd0);
    assign is_read  = (req_q.op == SRAM_OP_READ);
    assign byte_go  = (state == CT_GO);
    assign last     = (byte_cnt == last_idx);

    // Head word leaves the FIFO once its fourth byte is handed over
    assign wr_pop  = byte_go && is_data && !is_read && (byte_cnt[1:0] == 2'd3);
    assign rd_push = (state == CT_WAIT) && byte_done && is_data && is_read
                     && (byte_cnt[1:0] == 2'd3);

    always_comb begin
        case (byte_cnt)
            8'd0:    tx_byte = is_read ? `SRAM_CMD_READ : `SRAM_CMD_WRITE;
            8'd1:    tx_byte = req_q.addr[23:16];
            8'd2:    tx_byte = req_q.addr[15:8];
            8'd3:    tx_byte = req_q.addr[7:0];
            default: tx_byte = is_read ? 8'h00 : wr_head[{byte_cnt[1:0], 3'b000} +: 8];
        endcase
    end

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state     <= CT_IDLE;
            byte_cnt  <= '0;
            ctrl_done <= 1'b0;
        end else begin
            ctrl_done <= 1'b0;
            case (state)
                CT_IDLE: begin
                    if (req_valid) begin
                        byte_cnt <= '0;
                        state    <= CT_GO;
                    end
                end
                CT_GO: state <= CT_WAIT;
                CT_WAIT: begin
                    if (byte_done) begin
                        if (last) begin
                            ctrl_done <= 1'b1;
                            state     <= CT_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 8'd1;
                            state    <= CT_GO;
                        end
                    end
                end
                default: state <= CT_IDLE;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (state == CT_IDLE && req_valid) begin
            req_q <= req;
        end
        if ((state == CT_WAIT) && byte_done && is_data && is_read) begin
            rd_asm <= {rx_byte, rd_asm[23:8]};  // LSB arrives first
        end
    end

    sync_fifo #(
        .payload_t (sram_word_t),
        .DEPTH     (`SRAM_FIFO_DEPTH)
    ) u_wr_fifo (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .push      (wr_push),
        .push_data (wr_word),
        .pop       (wr_pop),
        .pop_data  (wr_head),
        .empty     (),
        .full      ()
    );

    sync_fifo #(
        .payload_t (sram_word_t),
        .DEPTH     (`SRAM_FIFO_DEPTH)
    ) u_rd_fifo (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .push      (rd_push),
        .push_data ({rx_byte, rd_asm}),
        .pop       (rd_pop),
        .pop_data  (rd_word),
        .empty     (rd_empty),
        .full      ()
    );

endmodule

// File: hdl/spi_byte_shifter.sv
`timescale 1ns/1ps
`include "sram_defines.svh"

// SPI mode 0 byte engine: sample miso on SCK rise, change mosi on SCK fall
module spi_byte_shifter (
    input  logic       pll_clk,
    input  logic       rst_n,
    input  logic       byte_go,
    input  logic [7:0] tx_byte,
    input  logic       last,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       cs_n,
    output logic       sck,
    output logic       mosi,
    input  logic       miso
);

    localparam int DW = $clog2(`SRAM_SPI_DIV + 1);

    logic          active;
    logic [DW-1:0] div_cnt;
    logic [2:0]    bit_cnt;
    logic          last_q;
    logic          tick;      // SCK edge due this cycle
    logic          start_byte;
    logic [7:0]    tx_sr;
    logic [7:0]    rx_sr;

    assign start_byte = byte_go && !active;
    assign tick       = active && (div_cnt == DW'(`SRAM_SPI_DIV - 1));

    // Done on the cycle of the eighth falling edge, rx_sr already holds the byte
    assign byte_done = tick && sck && (bit_cnt == 3'd7);
    assign rx_byte   = rx_sr;

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            active  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            last_q  <= 1'b0;
            cs_n    <= 1'b1;
            sck     <= 1'b0;
            mosi    <= 1'b0;
        end else if (start_byte) begin
            active  <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
            last_q  <= last;
            cs_n    <= 1'b0;        // Stays low from the first byte of a burst
            mosi    <= tx_byte[7];
        end else if (active) begin
            if (tick) begin
                div_cnt <= '0;
                sck     <= !sck;
                if (sck) begin      // Falling edge
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        active <= 1'b0;
                        cs_n   <= last_q;
                    end else begin
                        mosi <= tx_sr[6];
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (start_byte) begin
            tx_sr <= tx_byte;
        end else if (tick && sck) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
        if (tick && !sck) begin
            rx_sr <= {rx_sr[6:0], miso};    // MSB first
        end
    end

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

// Circular buffer with show-ahead output, DEPTH must be a power of two
module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 32
) (
    input  logic     pll_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int AW = $clog2(DEPTH);

    payload_t    mem [DEPTH];
    logic [AW:0] wr_ptr;  // Extra bit tells full from empty
    logic [AW:0] rd_ptr;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

// File: hdl/sram_pkg.sv
package sram_pkg;

    // Data word goes out least significant byte first
    typedef logic [31:0] sram_word_t;

    typedef logic [23:0] sram_addr_t; // Byte address

    typedef enum logic {
        SRAM_OP_WRITE,
        SRAM_OP_READ
    } sram_op_t;

    // Burst command from the self-test to the controller
    typedef struct packed {
        sram_op_t   op;
        sram_addr_t addr;
        logic [5:0] len;    // Words, 1 to 32
    } sram_req_t;

    typedef struct packed {
        logic       pass;
        logic [5:0] err_count;  // Mismatching words of the last run
    } test_result_t;

endpackage

// File: hdl/sram_defines.svh
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// Words per FIFO, also the longest burst the controller accepts
`define SRAM_FIFO_DEPTH 32

// pll_clk cycles per SCK half period
`define SRAM_SPI_DIV 2

// Serial SRAM command bytes
`define SRAM_CMD_READ  8'h03
`define SRAM_CMD_WRITE 8'h02

`endif
